/* compile.f */
hdl/usb_pkg.sv
hdl/usb_tx_controller.sv
hdl/usb_tx_bit_encoder.sv
hdl/usb_rx_bit_decoder.sv
hdl/usb_rx_byte_assembler.sv
hdl/usb_link_top.sv
tests/tb_usb_link.sv

/* run_sim.sh */
#!/bin/sh
# Build the loopback testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
	-f compile.f --top-module tb_usb_link -o tb_usb_link; then
	echo "Verilator build failed"
	exit 1
fi

if ! output=$(./obj_dir/tb_usb_link); then
	printf '%s\n' "$output"
	echo "Simulation exited with an error status"
	exit 1
fi

printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q -x "Verification passed"; then
	exit 0
else
	exit 1
fi

/* tests/tb_usb_link.sv */
// Loopback testbench for the link top; sends packets on the falling edge and checks every received byte
`timescale 1ns/100ps
`default_nettype none

module tb_usb_link;
	import usb_pkg::*;

	localparam int CLKS_PER_BIT   = 8;
	localparam int NUM_TESTS      = 6;
	// Payload words over all tests: 0 + 2 + 3 + 16 + 1 + 2
	localparam int TOTAL_WORDS    = 24;
	localparam int TIMEOUT_CYCLES = (TOTAL_WORDS + 4 * NUM_TESTS) * 16 * CLKS_PER_BIT * 2;

	logic        tb_read_enable = 1'b0;
	logic        rst_n;
	tx_word_u    tx_data;
	logic        transmit_start;
	logic        transmit_empty;
	logic        read_enable;
	logic        tx_error;
	logic        d_plus_out;
	logic        d_minus_out;
	logic        d_plus_in;
	logic        d_minus_in;
	logic [7:0]  rx_data;
	logic        write_enable;
	logic        packet_type;
	logic        rcv_error;

	logic [15:0] tx_words[$];
	logic [7:0]  exp_q[$];
	logic [31:0] rnd;
	integer      seed = 32'h042b_3594;
	int          error_count = 0;
	int          rcv_err_total = 0;
	int          tx_err_total = 0;
	int          test_num = 0;
	int          tests_passed = 0;
	int          cycle_count = 0;

	usb_link_top #(.CLKS_PER_BIT(CLKS_PER_BIT)) dut_i (
		.tb_read_enable (tb_read_enable),
		.rst_n          (rst_n),
		.tx_data        (tx_data),
		.transmit_start (transmit_start),
		.transmit_empty (transmit_empty),
		.read_enable    (read_enable),
		.tx_error       (tx_error),
		.d_plus_out     (d_plus_out),
		.d_minus_out    (d_minus_out),
		.d_plus_in      (d_plus_in),
		.d_minus_in     (d_minus_in),
		.rx_data        (rx_data),
		.write_enable   (write_enable),
		.packet_type    (packet_type),
		.rcv_error      (rcv_error)
	);

	// Line loopback
	assign d_plus_in  = d_plus_out;
	assign d_minus_in = d_minus_out;

	always #50 tb_read_enable = ~tb_read_enable;

	task report_error(input string msg);
		$display("ERROR at %0t ns: %s", $time, msg);
		error_count++;
	endtask

	// Source word, and its two bytes on the expected list when the receiver should see them
	task queue_word(input logic [15:0] w, input bit expect_rx);
		tx_words.push_back(w);
		if (expect_rx)
		begin
			exp_q.push_back(w[15:8]);
			exp_q.push_back(w[7:0]);
		end
	endtask

	// Outputs are sampled on the falling edge, half a cycle after they change
	always @(negedge tb_read_enable)
	begin
		if (rst_n)
		begin
			assert (!$isunknown({read_enable, write_enable, rcv_error}))
			else report_error("read_enable, write_enable or rcv_error is unknown");
			if (rcv_error)
				rcv_err_total++;
			if (tx_error)
				tx_err_total++;
			if (write_enable)
			begin
				assert (exp_q.size() != 0)
				else report_error($sformatf("unexpected byte %02h written", rx_data));
				if (exp_q.size() != 0)
				begin
					assert (rx_data == exp_q[0])
					else report_error($sformatf("rx_data %02h, expected %02h", rx_data, exp_q[0]));
					void'(exp_q.pop_front());
				end
			end
		end
	end

	// Header first, then one word per read_enable until the list runs out
	task send_packet(input logic [15:0] header, input bit restart_mid);
		int idx;
		bit done;
		idx  = 0;
		done = 1'b0;
		@(negedge tb_read_enable);
		tx_data.data_word = header;
		transmit_empty    = 1'b0;
		transmit_start    = 1'b1;
		@(negedge tb_read_enable);
		transmit_start = 1'b0;
		while (!done)
		begin
			@(negedge tb_read_enable);
			if (read_enable)
			begin
				if (idx < tx_words.size())
				begin
					tx_data.data_word = tx_words[idx];
					idx++;
					// Second start while the first payload word is on its way
					if (restart_mid && idx == 1)
					begin
						@(negedge tb_read_enable);
						transmit_start = 1'b1;
						@(negedge tb_read_enable);
						transmit_start = 1'b0;
					end
				end
				else
				begin
					transmit_empty = 1'b1;
					done           = 1'b1;
				end
			end
		end
	endtask

	// SE0 on the line, then the J bit that closes the EOP
	task wait_for_eop();
		while (d_plus_out || d_minus_out)
			@(negedge tb_read_enable);
		while (!d_plus_out)
			@(negedge tb_read_enable);
		repeat (CLKS_PER_BIT) @(negedge tb_read_enable);
	endtask

	task automatic run_test(input string name, input logic [15:0] header, input bit restart_mid,
		input int exp_rcv_err, input int exp_tx_err, input bit check_ptype, input bit exp_ptype);
		int errors_before;
		int rcv_before;
		int tx_before;
		errors_before = error_count;
		rcv_before    = rcv_err_total;
		tx_before     = tx_err_total;
		send_packet(header, restart_mid);
		wait_for_eop();
		assert (exp_q.size() == 0)
		else report_error($sformatf("%0d expected bytes never arrived", exp_q.size()));
		assert (rcv_err_total - rcv_before == exp_rcv_err)
		else report_error($sformatf("%0d rcv_error pulses, expected %0d",
			rcv_err_total - rcv_before, exp_rcv_err));
		assert (tx_err_total - tx_before == exp_tx_err)
		else report_error($sformatf("%0d tx_error pulses, expected %0d",
			tx_err_total - tx_before, exp_tx_err));
		if (check_ptype)
		begin
			assert (packet_type == exp_ptype)
			else report_error($sformatf("packet_type %0b, expected %0b", packet_type, exp_ptype));
		end
		test_num++;
		if (error_count == errors_before)
		begin
			tests_passed++;
			$display("Test %0d %s: passed", test_num, name);
		end
		else
			$display("Test %0d %s: FAILED", test_num, name);
		tx_words.delete();
		exp_q.delete();
	endtask

	initial
	begin : watchdog
		while (cycle_count < TIMEOUT_CYCLES)
		begin
			@(posedge tb_read_enable);
			cycle_count++;
		end
		$display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
		$display("Verification failed");
		$finish;
	end

	initial
	begin
		rst_n             = 1'b0;
		tx_data.data_word = 16'h0000;
		transmit_start    = 1'b0;
		transmit_empty    = 1'b0;
		repeat (4) @(negedge tb_read_enable);
		assert (!read_enable && !tx_error && !write_enable && !rcv_error && !packet_type &&
			d_plus_out && !d_minus_out)
		else report_error("outputs or lines not at reset values while rst_n is low");
		rst_n = 1'b1;

		queue_word(16'h0001, 1'b1);
		queue_word(16'h0203, 1'b1);
		run_test("data0 two words", {SYNC_BYTE, PID_DATA0}, 1'b0, 0, 0, 1'b1, 1'b1);

		// Follows a data packet so packet_type has to fall back to 0
		run_test("handshake", {SYNC_BYTE, PID_ACK}, 1'b0, 0, 0, 1'b1, 1'b0);

		// Long runs of ones force stuffed zeros
		queue_word(16'hFFFF, 1'b1);
		queue_word(16'hFFFF, 1'b1);
		queue_word(16'h7EFF, 1'b1);
		run_test("bit stuffing", {SYNC_BYTE, PID_DATA1}, 1'b0, 0, 0, 1'b1, 1'b1);

		for (int i = 0; i < 16; i++)
		begin
			rnd = $random(seed);
			queue_word(rnd[15:0], 1'b1);
		end
		run_test("random block", {SYNC_BYTE, PID_DATA0}, 1'b0, 0, 0, 1'b1, 1'b1);

		// Low nibble is not the complement of the high nibble
		queue_word(16'h1234, 1'b0);
		run_test("bad pid", {SYNC_BYTE, 8'hC4}, 1'b0, 1, 0, 1'b0, 1'b0);

		queue_word(16'hA55A, 1'b1);
		queue_word(16'h3CC3, 1'b1);
		run_test("busy restart", {SYNC_BYTE, PID_DATA0}, 1'b1, 0, 1, 1'b1, 1'b1);

		$display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
			test_num, tests_passed, test_num - tests_passed, error_count);
		if (error_count == 0 && tests_passed == NUM_TESTS)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

/* hdl/usb_link_top.sv */
// Link top: transmit path and receive path side by side, line pins brought out for loopback
`timescale 1ns/100ps
`default_nettype none

module usb_link_top #(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic              tb_read_enable,
	input  logic              rst_n,
	input  usb_pkg::tx_word_u tx_data,
	input  logic              transmit_start,
	input  logic              transmit_empty,
	output logic              read_enable,
	output logic              tx_error,
	output logic              d_plus_out,
	output logic              d_minus_out,
	input  logic              d_plus_in,
	input  logic              d_minus_in,
	output logic [7:0]        rx_data,
	output logic              write_enable,
	output logic              packet_type,
	output logic              rcv_error
);
	import usb_pkg::*;

	tx_byte_s tx_byte;
	logic     byte_take;
	rx_bit_s  rx_bit;

	usb_tx_controller tx_ctrl_i (
		.tb_read_enable (tb_read_enable),
		.rst_n          (rst_n),
		.tx_data        (tx_data),
		.transmit_start (transmit_start),
		.transmit_empty (transmit_empty),
		.read_enable    (read_enable),
		.tx_error       (tx_error),
		.tx_byte        (tx_byte),
		.byte_take      (byte_take)
	);

	usb_tx_bit_encoder #(.CLKS_PER_BIT(CLKS_PER_BIT)) tx_enc_i (
		.tb_read_enable (tb_read_enable),
		.rst_n          (rst_n),
		.tx_byte        (tx_byte),
		.byte_take      (byte_take),
		.d_plus_out     (d_plus_out),
		.d_minus_out    (d_minus_out)
	);

	usb_rx_bit_decoder #(.CLKS_PER_BIT(CLKS_PER_BIT)) rx_dec_i (
		.tb_read_enable (tb_read_enable),
		.rst_n          (rst_n),
		.d_plus_in      (d_plus_in),
		.d_minus_in     (d_minus_in),
		.rx_bit         (rx_bit)
	);

	usb_rx_byte_assembler rx_asm_i (
		.tb_read_enable (tb_read_enable),
		.rst_n          (rst_n),
		.rx_bit         (rx_bit),
		.rx_data        (rx_data),
		.write_enable   (write_enable),
		.packet_type    (packet_type),
		.rcv_error      (rcv_error)
	);

endmodule

`default_nettype wire

/* hdl/usb_rx_byte_assembler.sv */
// Receive framer: hunts for SYNC, checks the PID and writes out payload bytes
`timescale 1ns/100ps
`default_nettype none

module usb_rx_byte_assembler (
	input  logic             tb_read_enable,
	input  logic             rst_n,
	input  usb_pkg::rx_bit_s rx_bit,
	output logic [7:0]       rx_data,
	output logic             write_enable,
	output logic             packet_type,
	output logic             rcv_error
);
	import usb_pkg::*;

	typedef enum logic [1:0] {
		ASM_HUNT,
		ASM_PID,
		ASM_DATA,
		ASM_WAIT_EOP
	} asm_state_e;

	asm_state_e state;
	logic [7:0] shift_q;
	logic [7:0] next_byte;
	logic [2:0] bit_cnt;
	logic       byte_done;

	// Bits arrive LSB first, so they enter at the top
	assign next_byte = {rx_bit.value, shift_q[7:1]};
	assign byte_done = rx_bit.valid && (bit_cnt == 3'd7) && !rx_bit.eop && !rx_bit.stuff_err;

	always_ff @(posedge tb_read_enable or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state        <= ASM_HUNT;
			shift_q      <= '1;
			bit_cnt      <= '0;
			write_enable <= 1'b0;
			rcv_error    <= 1'b0;
			packet_type  <= 1'b0;
		end
		else
		begin
			write_enable <= 1'b0;
			rcv_error    <= 1'b0;
			if (rx_bit.valid)
			begin
				shift_q <= next_byte;
				bit_cnt <= bit_cnt + 3'd1;
			end
			case (state)
				ASM_HUNT:
					if (rx_bit.valid && next_byte == SYNC_BYTE)
					begin
						state   <= ASM_PID;
						bit_cnt <= '0;
					end
				ASM_PID, ASM_DATA:
					if (rx_bit.stuff_err)
					begin
						rcv_error <= 1'b1;
						state     <= ASM_WAIT_EOP;
					end
					else if (rx_bit.eop)
					begin
						// Missing PID or a partial byte
						rcv_error <= (state == ASM_PID) || (bit_cnt != 3'd0);
						shift_q   <= '1;
						state     <= ASM_HUNT;
					end
					else if (byte_done && state == ASM_PID)
					begin
						if (next_byte[3:0] == ~next_byte[7:4])
						begin
							packet_type <= (next_byte == PID_DATA0) || (next_byte == PID_DATA1);
							state       <= ASM_DATA;
						end
						else
						begin
							rcv_error <= 1'b1;
							state     <= ASM_WAIT_EOP;
						end
					end
					else if (byte_done)
						write_enable <= 1'b1;
				default:
					if (rx_bit.eop)
					begin
						shift_q <= '1;
						state   <= ASM_HUNT;
					end
			endcase
		end
	end

	always_ff @(posedge tb_read_enable)
	begin
		if (byte_done && state == ASM_DATA)
			rx_data <= next_byte;
	end

endmodule

`default_nettype wire

/* hdl/usb_rx_bit_decoder.sv */
// Line decoder: recovers bit timing, undoes NRZI and bit stuffing, and reports EOP
`timescale 1ns/100ps
`default_nettype none

module usb_rx_bit_decoder #(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic             tb_read_enable,
	input  logic             rst_n,
	input  logic             d_plus_in,
	input  logic             d_minus_in,
	output usb_pkg::rx_bit_s rx_bit
);
	import usb_pkg::*;

	localparam int               PHASE_W      = $clog2(CLKS_PER_BIT);
	localparam logic [PHASE_W-1:0] LAST_PHASE   = PHASE_W'(CLKS_PER_BIT - 1);
	localparam logic [PHASE_W-1:0] SAMPLE_PHASE = PHASE_W'(CLKS_PER_BIT / 2 - 1);

	line_state_e        line_meta;
	line_state_e        line_sync;
	line_state_e        line_prev;
	line_state_e        last_state;
	logic [PHASE_W-1:0] phase;
	logic [2:0]         ones_cnt;
	logic               active;
	logic               se0_seen;
	logic               sample;
	logic               nrzi_bit;

	// Two flop synchronizer, third stage for edge detect
	always_ff @(posedge tb_read_enable or negedge rst_n)
	begin
		if (!rst_n)
		begin
			line_meta <= LINE_J;
			line_sync <= LINE_J;
			line_prev <= LINE_J;
			phase     <= '0;
		end
		else
		begin
			line_meta <= line_state_e'({d_plus_in, d_minus_in});
			line_sync <= line_meta;
			line_prev <= line_sync;
			// Any line change realigns the bit clock
			if (line_sync != line_prev || phase == LAST_PHASE)
				phase <= '0;
			else
				phase <= phase + 1'b1;
		end
	end

	assign sample   = (phase == SAMPLE_PHASE);
	assign nrzi_bit = (line_sync == last_state);

	always_ff @(posedge tb_read_enable or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rx_bit     <= '0;
			last_state <= LINE_J;
			ones_cnt   <= '0;
			active     <= 1'b0;
			se0_seen   <= 1'b0;
		end
		else
		begin
			rx_bit <= '0;
			if (sample)
			begin
				case (line_sync)
					LINE_SE0:
						if (active && se0_seen)
						begin
							rx_bit.eop <= 1'b1;
							active     <= 1'b0;
							se0_seen   <= 1'b0;
							ones_cnt   <= '0;
							last_state <= LINE_J;
						end
						else if (active)
							se0_seen <= 1'b1;
					LINE_J, LINE_K:
					begin
						se0_seen <= 1'b0;
						// First K after idle opens the packet
						if (active || line_sync == LINE_K)
						begin
							active     <= 1'b1;
							last_state <= line_sync;
							if (ones_cnt == 3'd6)
							begin
								// Stuffed zero is dropped, a seventh one is an error
								ones_cnt         <= '0;
								rx_bit.stuff_err <= nrzi_bit;
							end
							else
							begin
								rx_bit.valid <= 1'b1;
								rx_bit.value <= nrzi_bit;
								ones_cnt     <= nrzi_bit ? ones_cnt + 3'd1 : 3'd0;
							end
						end
					end
					// SE1 is never driven by the transmitter
					default:
						se0_seen <= 1'b0;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/usb_tx_bit_encoder.sv */
// Line encoder: serializes bytes LSB first with bit stuffing and NRZI, then drives EOP
`timescale 1ns/100ps
`default_nettype none

module usb_tx_bit_encoder #(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic              tb_read_enable,
	input  logic              rst_n,
	input  usb_pkg::tx_byte_s tx_byte,
	output logic              byte_take,
	output logic              d_plus_out,
	output logic              d_minus_out
);
	import usb_pkg::*;

	localparam int                CNT_W    = $clog2(CLKS_PER_BIT);
	localparam logic [CNT_W-1:0]  LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);

	typedef enum logic [1:0] {
		ENC_IDLE,
		ENC_DATA,
		ENC_EOP,
		ENC_EOP_J
	} enc_state_e;

	enc_state_e       state;
	line_state_e      line_q;
	line_state_e      line_flip;
	logic [CNT_W-1:0] bit_cnt;
	logic [7:0]       shift_q;
	logic [2:0]       bits_left;
	logic [2:0]       ones_cnt;
	logic             eop_second;
	logic             tick;
	logic             byte_end;
	logic             load_byte;
	logic             emit_bit;
	logic             stuff_bit;
	logic             data_bit;

	always_comb
	begin
		tick      = (bit_cnt == LAST_CNT);
		stuff_bit = (state == ENC_DATA) && tick && (ones_cnt == 3'd6);
		// Current byte fully sent and no stuffed zero pending
		byte_end  = (state == ENC_DATA) && tick && (ones_cnt != 3'd6) && (bits_left == 3'd0);
		load_byte = ((state == ENC_IDLE) || byte_end) && tx_byte.valid;
		byte_take = load_byte || (byte_end && tx_byte.last);
		emit_bit  = load_byte || ((state == ENC_DATA) && tick && (ones_cnt != 3'd6) &&
			(bits_left != 3'd0));
		data_bit  = load_byte ? tx_byte.data[0] : shift_q[0];
		line_flip = (line_q == LINE_J) ? LINE_K : LINE_J;
	end

	always_ff @(posedge tb_read_enable or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state      <= ENC_IDLE;
			line_q     <= LINE_J;
			bit_cnt    <= '0;
			bits_left  <= '0;
			ones_cnt   <= '0;
			eop_second <= 1'b0;
		end
		else
		begin
			if (state == ENC_IDLE || tick)
				bit_cnt <= '0;
			else
				bit_cnt <= bit_cnt + 1'b1;

			if (emit_bit)
			begin
				// NRZI: zero toggles, one holds
				line_q    <= data_bit ? line_q : line_flip;
				ones_cnt  <= data_bit ? ones_cnt + 3'd1 : 3'd0;
				bits_left <= load_byte ? 3'd7 : bits_left - 3'd1;
				state     <= ENC_DATA;
			end
			else if (stuff_bit)
			begin
				line_q   <= line_flip;
				ones_cnt <= '0;
			end
			else if (byte_end)
			begin
				line_q     <= LINE_SE0;
				ones_cnt   <= '0;
				eop_second <= 1'b0;
				state      <= ENC_EOP;
			end
			else if (tick && state == ENC_EOP)
			begin
				if (eop_second)
				begin
					line_q <= LINE_J;
					state  <= ENC_EOP_J;
				end
				else
					eop_second <= 1'b1;
			end
			else if (tick && state == ENC_EOP_J)
				state <= ENC_IDLE;
		end
	end

	always_ff @(posedge tb_read_enable)
	begin
		if (load_byte)
			shift_q <= {1'b0, tx_byte.data[7:1]};
		else if (emit_bit)
			shift_q <= {1'b0, shift_q[7:1]};
	end

	assign d_plus_out  = line_q[1];
	assign d_minus_out = line_q[0];

endmodule

`default_nettype wire

/* hdl/usb_tx_controller.sv */
// Transmit sequencer: fetches header and payload words and offers them to the encoder byte by byte
`timescale 1ns/100ps
`default_nettype none

module usb_tx_controller (
	input  logic              tb_read_enable,
	input  logic              rst_n,
	input  usb_pkg::tx_word_u tx_data,
	input  logic              transmit_start,
	input  logic              transmit_empty,
	output logic              read_enable,
	output logic              tx_error,
	output usb_pkg::tx_byte_s tx_byte,
	input  logic              byte_take
);
	import usb_pkg::*;

	typedef enum logic [2:0] {
		CTL_IDLE,
		CTL_HDR_HI,
		CTL_HDR_LO,
		CTL_PAY_HI,
		CTL_PAY_LO,
		CTL_FETCH,
		CTL_LAST
	} ctl_state_e;

	ctl_state_e state;
	tx_word_u   word_q;

	always_ff @(posedge tb_read_enable or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state    <= CTL_IDLE;
			tx_error <= 1'b0;
		end
		else
		begin
			// A start during a packet is dropped and flagged
			tx_error <= transmit_start && (state != CTL_IDLE);
			case (state)
				CTL_IDLE:
					if (transmit_start)
						state <= CTL_HDR_HI;
				CTL_HDR_HI:
					if (byte_take)
						state <= CTL_HDR_LO;
				CTL_HDR_LO, CTL_PAY_LO:
					if (byte_take)
						state <= CTL_FETCH;
				CTL_PAY_HI:
					if (byte_take)
						state <= CTL_PAY_LO;
				CTL_FETCH:
					state <= transmit_empty ? CTL_LAST : CTL_PAY_HI;
				default:
					if (byte_take)
						state <= CTL_IDLE;
			endcase
		end
	end

	// Word holding register
	always_ff @(posedge tb_read_enable)
	begin
		if ((state == CTL_IDLE && transmit_start) || (state == CTL_FETCH && !transmit_empty))
			word_q <= tx_data;
	end

	// Source sees the request for the one cycle spent in fetch
	assign read_enable = (state == CTL_FETCH);

	always_comb
	begin
		tx_byte = '0;
		case (state)
			CTL_HDR_HI:
			begin
				tx_byte.valid = 1'b1;
				tx_byte.data  = word_q.header.sync;
			end
			CTL_HDR_LO:
			begin
				tx_byte.valid = 1'b1;
				tx_byte.data  = word_q.header.pid;
			end
			CTL_PAY_HI:
			begin
				tx_byte.valid = 1'b1;
				tx_byte.data  = word_q.data_word[15:8];
			end
			CTL_PAY_LO:
			begin
				tx_byte.valid = 1'b1;
				tx_byte.data  = word_q.data_word[7:0];
			end
			// Source empty, so the byte being shifted is the final one
			CTL_LAST:
				tx_byte.last = 1'b1;
			default:
				tx_byte = '0;
		endcase
	end

endmodule

`default_nettype wire

/* hdl/usb_pkg.sv */
// Shared link types, PID constants and line encodings; imported by every RTL block and the testbench
`default_nettype none

package usb_pkg;

	// Fixed link constants
	localparam logic [7:0] SYNC_BYTE = 8'h80;
	localparam logic [7:0] PID_ACK   = 8'hD2;
	localparam logic [7:0] PID_DATA0 = 8'hC3;
	localparam logic [7:0] PID_DATA1 = 8'h4B;

	// Line state as {d_plus, d_minus}
	typedef enum logic [1:0] {
		LINE_SE0 = 2'b00,
		LINE_K   = 2'b01,
		LINE_J   = 2'b10,
		LINE_SE1 = 2'b11
	} line_state_e;

	// First word of a packet
	typedef struct packed {
		logic [7:0] sync;
		logic [7:0] pid;
	} tx_header_s;

	// One source word, read as header or as payload
	typedef union packed {
		logic [15:0] data_word;
		tx_header_s  header;
	} tx_word_u;

	// Byte offer from controller to encoder
	// last without valid tags the byte already inside the encoder
	typedef struct packed {
		logic       valid;
		logic       last;
		logic [7:0] data;
	} tx_byte_s;

	// Decoded bit event from decoder to assembler
	typedef struct packed {
		logic valid;
		logic value;
		logic eop;
		logic stuff_err;
	} rx_bit_s;

endpackage

`default_nettype wire
